// File: router_pkg.sv
// Shared types and sizes for the five-port mesh router control path.
package router_pkg;

	// Router and packet sizes.
	localparam int NUM_PORTS  = 5;
	localparam int COORD_W    = 4;                  // Bits per mesh coordinate.
	localparam int PKT_FLITS  = 4;                  // Flits per packet, header included.
	localparam int BUF_DEPTH  = 4;                  // Slots in each downstream buffer.
	localparam int CREDIT_W   = 3;                  // Must hold the value BUF_DEPTH.
	localparam int FLIT_CNT_W = $clog2(PKT_FLITS);  // Width of the per-input flit counter.

	// Port names, used both as a route destination and as a crossbar source.
	typedef enum logic [2:0] {
		PORT_N = 3'd0,
		PORT_S = 3'd1,
		PORT_W = 3'd2,
		PORT_E = 3'd3,
		PORT_L = 3'd4
	} port_e;

	// Mesh address of a router or of a packet destination.
	typedef struct packed {
		logic [COORD_W-1:0] y;
		logic [COORD_W-1:0] x;
	} coord_t;

	// Request from an input controller to the switch allocator.
	typedef struct packed {
		logic  valid;  // A flit is waiting and its route is known.
		port_e dest;   // Output chosen by the YX rule.
		logic  tail;   // The waiting flit closes the packet.
	} route_req_t;

	// Crossbar select for one output.
	typedef struct packed {
		logic  valid;  // A flit leaves through this output in this cycle.
		port_e src;    // Input that sends it.
	} xbar_sel_t;

	// Input controller states.
	typedef enum logic {
		RT_IDLE   = 1'b0,
		RT_ACTIVE = 1'b1
	} route_state_e;

endpackage

// File: input_route_ctrl.sv
// Input route controller: YX route of each packet, next-hop register and flit tracking.
`timescale 1ns/1ps

module input_route_ctrl (
	input  logic                 clk,
	input  logic                 rst_n_i,
	input  router_pkg::coord_t   router_addr_i,
	input  logic                 ib_valid_i,
	input  router_pkg::coord_t   hdr_dest_i,
	input  logic                 grant_i,
	output router_pkg::route_req_t req_o
);

	import router_pkg::*;

	route_state_e          state_q;
	port_e                 yx_dest;     // Route of the header that is waiting now.
	port_e                 next_hop_q;  // Route held for the packet in flight.
	logic [FLIT_CNT_W-1:0] flit_cnt_q;  // Flits of the current packet already read.
	logic                  last_flit;
	logic                  pkt_start;

	// Y is resolved first, so a packet only turns east or west in the row of its target.
	always_comb begin
		if (hdr_dest_i.y > router_addr_i.y) begin
			yx_dest = PORT_S;
		end else if (hdr_dest_i.y < router_addr_i.y) begin
			yx_dest = PORT_N;
		end else if (hdr_dest_i.x > router_addr_i.x) begin
			yx_dest = PORT_E;
		end else if (hdr_dest_i.x < router_addr_i.x) begin
			yx_dest = PORT_W;
		end else begin
			yx_dest = PORT_L;  // The packet has arrived.
		end
	end

	assign pkt_start = (state_q == RT_IDLE) && ib_valid_i;
	assign last_flit = (flit_cnt_q == FLIT_CNT_W'(PKT_FLITS - 1));

	always_ff @(posedge clk) begin
		if (!rst_n_i) begin
			state_q    <= RT_IDLE;
			flit_cnt_q <= '0;
		end else if (state_q == RT_IDLE) begin
			flit_cnt_q <= '0;
			if (ib_valid_i) begin
				state_q <= RT_ACTIVE;  // Header seen, the route is ready next cycle.
			end
		end else if (grant_i) begin
			flit_cnt_q <= flit_cnt_q + 1'b1;
			if (last_flit) begin
				state_q <= RT_IDLE;  // Tail read, the next flit is a new header.
			end
		end
	end

	// The next hop only changes when a new packet begins.
	always_ff @(posedge clk) begin
		if (pkt_start) begin
			next_hop_q <= yx_dest;
		end
	end

	// A request needs a flit in the buffer in the same cycle.
	always_comb begin
		req_o.valid = (state_q == RT_ACTIVE) && ib_valid_i;
		req_o.dest  = next_hop_q;
		req_o.tail  = last_flit;
	end

	// The allocator may only grant an input that is asking.
	a_grant_needs_req: assert property (@(posedge clk) disable iff (!rst_n_i)
		grant_i |-> req_o.valid);

	// The header destination stays constant for the whole packet.
	a_route_stable: assert property (@(posedge clk) disable iff (!rst_n_i)
		(state_q == RT_ACTIVE) && ib_valid_i |-> yx_dest == next_hop_q);

endmodule

// File: output_credit_ctrl.sv
// Output credit controller: counts the free slots of the downstream input buffer.
`timescale 1ns/1ps

module output_credit_ctrl (
	input  logic clk,
	input  logic rst_n_i,
	input  logic flit_sent_i,
	input  logic credit_i,
	output logic has_credit_o
);

	import router_pkg::*;

	logic [CREDIT_W-1:0] credit_q;  // Free slots downstream.

	// The downstream buffer starts empty, so every slot is free after reset.
	always_ff @(posedge clk) begin
		if (!rst_n_i) begin
			credit_q <= CREDIT_W'(BUF_DEPTH);
		end else if (flit_sent_i && !credit_i) begin
			credit_q <= credit_q - 1'b1;  // A flit now occupies one slot.
		end else if (credit_i && !flit_sent_i) begin
			credit_q <= credit_q + 1'b1;  // The downstream router freed one slot.
		end
	end

	// A send and a return in the same cycle cancel out.

	assign has_credit_o = (credit_q != '0);

	// The allocator must not send into a full downstream buffer.
	a_no_underflow: assert property (@(posedge clk) disable iff (!rst_n_i)
		flit_sent_i |-> credit_q != '0);

	// Downstream never returns more slots than it has.
	a_no_overflow: assert property (@(posedge clk) disable iff (!rst_n_i)
		credit_i && !flit_sent_i |-> credit_q < CREDIT_W'(BUF_DEPTH));

endmodule

// File: switch_allocator.sv
// Switch allocator: round-robin wormhole arbitration of every output, gated by credit.
`timescale 1ns/1ps

module switch_allocator (
	input  logic                                clk,
	input  logic                                rst_n_i,
	input  router_pkg::route_req_t              req_i [router_pkg::NUM_PORTS],
	input  logic [router_pkg::NUM_PORTS-1:0]    has_credit_i,
	output logic [router_pkg::NUM_PORTS-1:0]    grant_o,
	output logic [router_pkg::NUM_PORTS-1:0]    flit_sent_o,
	output router_pkg::xbar_sel_t               xbar_sel_o [router_pkg::NUM_PORTS]
);

	import router_pkg::*;

	logic [NUM_PORTS-1:0] lock_q;                // Output is held by a packet in flight.
	port_e                owner_q   [NUM_PORTS];  // Input that holds a locked output.
	port_e                rr_ptr_q  [NUM_PORTS];  // First input to look at on the next pick.
	logic [NUM_PORTS-1:0] req_vec   [NUM_PORTS];  // Per output, the inputs that want it.
	port_e                winner    [NUM_PORTS];
	logic [NUM_PORTS-1:0] sel_valid;              // A flit crosses to this output now.
	logic [NUM_PORTS-1:0] sel_tail;               // That flit is the packet's last.

	// First requesting input at or after ptr, going round.
	function automatic port_e rr_pick(input logic [NUM_PORTS-1:0] reqs, input port_e ptr);
		int    idx;
		port_e pick;
		pick = ptr;
		// Scan from the far end, so the nearest request is the one that stays.
		for (int i = NUM_PORTS - 1; i >= 0; i--) begin
			idx = (int'(ptr) + i) % NUM_PORTS;
			if (reqs[idx]) begin
				pick = port_e'(idx);
			end
		end
		return pick;
	endfunction

	function automatic port_e next_port(input port_e p);
		return (p == PORT_L) ? PORT_N : port_e'(p + 3'd1);
	endfunction

	always_comb begin
		for (int q = 0; q < NUM_PORTS; q++) begin
			for (int p = 0; p < NUM_PORTS; p++) begin
				req_vec[q][p] = req_i[p].valid && (req_i[p].dest == port_e'(q));
			end
			// A locked output only listens to its owner.
			winner[q]    = lock_q[q] ? owner_q[q] : rr_pick(req_vec[q], rr_ptr_q[q]);
			sel_valid[q] = req_vec[q][winner[q]] && has_credit_i[q];
			sel_tail[q]  = req_i[winner[q]].tail;
		end
	end

	// Each input asks for one output only, so it collects one grant at most.
	always_comb begin
		grant_o = '0;
		for (int q = 0; q < NUM_PORTS; q++) begin
			if (sel_valid[q]) begin
				grant_o[winner[q]] = 1'b1;
			end
		end
	end

	assign flit_sent_o = sel_valid;

	always_comb begin
		for (int q = 0; q < NUM_PORTS; q++) begin
			xbar_sel_o[q].valid = sel_valid[q];
			xbar_sel_o[q].src   = winner[q];
		end
	end

	// Lock on a body flit, release and rotate on the tail.
	always_ff @(posedge clk) begin
		if (!rst_n_i) begin
			lock_q <= '0;
			for (int q = 0; q < NUM_PORTS; q++) begin
				rr_ptr_q[q] <= PORT_N;
			end
		end else begin
			for (int q = 0; q < NUM_PORTS; q++) begin
				if (sel_valid[q] && sel_tail[q]) begin
					lock_q[q]   <= 1'b0;
					rr_ptr_q[q] <= next_port(winner[q]);  // The winner goes to the back.
				end else if (sel_valid[q]) begin
					lock_q[q] <= 1'b1;
				end
			end
		end
	end

	always_ff @(posedge clk) begin
		for (int q = 0; q < NUM_PORTS; q++) begin
			if (sel_valid[q] && !sel_tail[q]) begin
				owner_q[q] <= winner[q];
			end
		end
	end

	for (genvar q = 0; q < NUM_PORTS; q++) begin : g_chk
		// A packet in flight keeps asking for the output that it holds.
		a_owner_hold: assert property (@(posedge clk) disable iff (!rst_n_i)
			lock_q[q] && req_i[owner_q[q]].valid |->
				req_i[owner_q[q]].dest == port_e'(q));
	end

endmodule

// File: router_arbiter.sv
// Router control path: per-input route controllers, per-output credit counters and allocator.
`timescale 1ns/1ps

module router_arbiter (
	input  logic                             clk,
	input  logic                             rst_n_i,
	input  router_pkg::coord_t               router_addr_i,
	input  logic [router_pkg::NUM_PORTS-1:0] ib_valid_i,
	input  router_pkg::coord_t               hdr_dest_i [router_pkg::NUM_PORTS],
	input  logic [router_pkg::NUM_PORTS-1:0] credit_i,
	output logic [router_pkg::NUM_PORTS-1:0] ib_read_o,
	output logic [router_pkg::NUM_PORTS-1:0] credit_o,
	output router_pkg::xbar_sel_t            xbar_sel_o [router_pkg::NUM_PORTS]
);

	import router_pkg::*;

	route_req_t           route_req [NUM_PORTS];  // Input controllers to allocator.
	logic [NUM_PORTS-1:0] grant;                  // One flit read from each granted input.
	logic [NUM_PORTS-1:0] has_credit;
	logic [NUM_PORTS-1:0] flit_sent;

	// One route controller per input port.
	for (genvar p = 0; p < NUM_PORTS; p++) begin : g_in
		input_route_ctrl i_input_route_ctrl (
			.clk           (clk),
			.rst_n_i       (rst_n_i),
			.router_addr_i (router_addr_i),
			.ib_valid_i    (ib_valid_i[p]),
			.hdr_dest_i    (hdr_dest_i[p]),
			.grant_i       (grant[p]),
			.req_o         (route_req[p])
		);
	end

	// One credit counter per output port.
	for (genvar q = 0; q < NUM_PORTS; q++) begin : g_out
		output_credit_ctrl i_output_credit_ctrl (
			.clk          (clk),
			.rst_n_i      (rst_n_i),
			.flit_sent_i  (flit_sent[q]),
			.credit_i     (credit_i[q]),
			.has_credit_o (has_credit[q])
		);
	end

	switch_allocator i_switch_allocator (
		.clk          (clk),
		.rst_n_i      (rst_n_i),
		.req_i        (route_req),
		.has_credit_i (has_credit),
		.grant_o      (grant),
		.flit_sent_o  (flit_sent),
		.xbar_sel_o   (xbar_sel_o)
	);

	// Every read frees a slot in the input buffer, so it is also the upstream credit.
	assign ib_read_o = grant;
	assign credit_o  = grant;

endmodule

// File: tb_router_arbiter.sv
// Testbench for the router control path: table-driven packets, buffer and sink models, checks.
`timescale 1ns/1ps

module tb_router_arbiter;

	import router_pkg::*;

	localparam int NUM_ROWS   = 11;
	localparam int MAX_PKTS   = 6;                // Longest packet list on one output.
	localparam int ROW_CYCLES = 200 * PKT_FLITS;  // Cycle budget of one table row.

	typedef port_e [MAX_PKTS-1:0] order_t;  // Entry 0 is the first packet.

	// One stimulus row with its expected results.
	typedef struct packed {
		coord_t                    addr;
		logic [NUM_PORTS-1:0][2:0] pkts;   // Packets queued at each input.
		coord_t [NUM_PORTS-1:0]    dest;   // Header destination of each input.
		logic [NUM_PORTS-1:0][7:0] hold;   // No credit returns on that output before this cycle.
		logic [NUM_PORTS-1:0][2:0] delay;  // Cycles from a flit to its returned credit.
		logic                      rnd;    // Random credit delays instead.
		order_t [NUM_PORTS-1:0]    order;  // Expected packet sources per output.
	} row_t;

	logic                 clk;
	logic                 rst_n_i;
	coord_t               router_addr_i;
	logic [NUM_PORTS-1:0] ib_valid_i;
	coord_t               hdr_dest_i [NUM_PORTS];
	logic [NUM_PORTS-1:0] credit_i;
	logic [NUM_PORTS-1:0] ib_read_o;
	logic [NUM_PORTS-1:0] credit_o;
	xbar_sel_t            xbar_sel_o [NUM_PORTS];

	row_t  rows [NUM_ROWS];
	port_e exp_order [NUM_PORTS][$];  // Packet order from the reference model.
	int    release_q [NUM_PORTS][$];  // Cycles at which owed credits may go back.
	int    buf_flits [NUM_PORTS];     // Flits left in each input buffer model.
	int    credits [NUM_PORTS];       // Reference credit count of each output.
	int    pkt_idx [NUM_PORTS];
	int    flit_in_pkt [NUM_PORTS];
	int    sent_flits [NUM_PORTS];
	int    cyc;                       // Cycles since reset was released.

	router_arbiter i_router_arbiter (
		.clk           (clk),
		.rst_n_i       (rst_n_i),
		.router_addr_i (router_addr_i),
		.ib_valid_i    (ib_valid_i),
		.hdr_dest_i    (hdr_dest_i),
		.credit_i      (credit_i),
		.ib_read_o     (ib_read_o),
		.credit_o      (credit_o),
		.xbar_sel_o    (xbar_sel_o)
	);

	initial begin
		clk = 1'b0;
		forever #2 clk = ~clk;
	end

	task automatic stop_failed();
		$display("sim failed");
		$fatal(1, "run stopped at the first error");
	endtask

	task automatic fail_value(input string msg);
		$display("Fail at %0t ns: %s", $time, msg);
		stop_failed();
	endtask

	task automatic check_sel(input xbar_sel_t got, input xbar_sel_t exp, input string what);
		if (got !== exp) begin
			fail_value($sformatf("%s is %0b/%s, expected %0b/%s", what, got.valid,
				got.src.name(), exp.valid, exp.src.name()));
		end
	endtask

	task automatic check_port(input port_e got, input port_e exp, input string what);
		if (got !== exp) begin
			fail_value($sformatf("%s is %s, expected %s", what, got.name(), exp.name()));
		end
	endtask

	task automatic check_bit(input logic got, input logic exp, input string what);
		if (got !== exp) begin
			fail_value($sformatf("%s is %b, expected %b", what, got, exp));
		end
	endtask

	task automatic check_count(input int got, input int exp, input string what);
		if (got != exp) begin
			fail_value($sformatf("%s is %0d, expected %0d", what, got, exp));
		end
	endtask

	// YX rule worked out from signed coordinate differences.
	function automatic port_e yx_route(input coord_t here, input coord_t to);
		int dy;
		int dx;
		dy = int'(to.y) - int'(here.y);
		dx = int'(to.x) - int'(here.x);
		if (dy != 0) begin
			return (dy > 0) ? PORT_S : PORT_N;
		end
		if (dx != 0) begin
			return (dx > 0) ? PORT_E : PORT_W;
		end
		return PORT_L;
	endfunction

	function automatic order_t seq(input port_e a, input port_e b, input port_e c,
		input port_e d, input port_e e, input port_e f);
		order_t o;
		o[0] = a;
		o[1] = b;
		o[2] = c;
		o[3] = d;
		o[4] = e;
		o[5] = f;
		return o;
	endfunction

	// Every input sends all its packets to one output, and all of them wait from the start.
	task automatic build_model(input row_t r);
		int left [NUM_PORTS];
		int ptr;
		int cand;
		int found;
		for (int q = 0; q < NUM_PORTS; q++) begin
			exp_order[q].delete();
			for (int p = 0; p < NUM_PORTS; p++) begin
				left[p] = (yx_route(r.addr, r.dest[p]) == port_e'(q)) ? int'(r.pkts[p]) : 0;
			end
			ptr = int'(PORT_N);
			repeat (MAX_PKTS) begin
				found = -1;
				for (int k = 0; k < NUM_PORTS; k++) begin
					cand = (ptr + k) % NUM_PORTS;
					if (found < 0 && left[cand] > 0) begin
						found = cand;
					end
				end
				if (found >= 0) begin
					exp_order[q].push_back(port_e'(found));
					left[found]--;
					ptr = (found + 1) % NUM_PORTS;  // The winner moves behind the others.
				end
			end
		end
	endtask

	task automatic compare_table(input row_t r, input int idx);
		for (int q = 0; q < NUM_PORTS; q++) begin
			for (int k = 0; k < exp_order[q].size(); k++) begin
				if (r.order[q][k] != exp_order[q][k]) begin
					$display("Row %0d: table order of output %0d disagrees with the model", idx, q);
					stop_failed();
				end
			end
		end
	endtask

	task automatic reset_row(input row_t r);
		@(negedge clk);
		rst_n_i       = 1'b0;
		ib_valid_i    = '0;
		credit_i      = '0;
		router_addr_i = r.addr;
		for (int p = 0; p < NUM_PORTS; p++) begin
			hdr_dest_i[p] = r.dest[p];
			buf_flits[p]  = int'(r.pkts[p]) * PKT_FLITS;
			credits[p]    = BUF_DEPTH;
			release_q[p].delete();
			pkt_idx[p]     = 0;
			flit_in_pkt[p] = 0;
			sent_flits[p]  = 0;
		end
		repeat (2) begin
			@(posedge clk);
			#1;
			for (int p = 0; p < NUM_PORTS; p++) begin
				check_bit(ib_read_o[p], 1'b0, $sformatf("read %0d in reset", p));
				check_bit(credit_o[p], 1'b0, $sformatf("credit %0d in reset", p));
				check_bit(xbar_sel_o[p].valid, 1'b0, $sformatf("select %0d in reset", p));
			end
		end
		cyc = 0;
	endtask

	// One clock cycle: drive at the falling edge, then check just before the rising edge.
	task automatic step_cycle(input row_t r);
		logic [NUM_PORTS-1:0] exp_read;
		xbar_sel_t            exp_sel;
		port_e                src;
		int                   ret_delay;
		@(negedge clk);
		rst_n_i = 1'b1;
		for (int p = 0; p < NUM_PORTS; p++) begin
			ib_valid_i[p] = (buf_flits[p] > 0);
		end
		for (int q = 0; q < NUM_PORTS; q++) begin
			credit_i[q] = 1'b0;
			if (release_q[q].size() > 0 && release_q[q][0] <= cyc) begin
				credit_i[q] = 1'b1;  // At most one slot is freed per cycle.
				void'(release_q[q].pop_front());
			end
		end
		#1;
		exp_read = '0;
		for (int q = 0; q < NUM_PORTS; q++) begin
			if (credits[q] == 0) begin
				check_bit(xbar_sel_o[q].valid, 1'b0, $sformatf("select %0d at zero credit", q));
			end
			if (xbar_sel_o[q].valid) begin
				if (pkt_idx[q] >= exp_order[q].size()) begin
					fail_value($sformatf("output %0d sends a packet the model does not expect", q));
				end
				src = exp_order[q][pkt_idx[q]];
				if (flit_in_pkt[q] == 0) begin
					check_port(xbar_sel_o[q].src, src,
						$sformatf("source of packet %0d on output %0d", pkt_idx[q], q));
				end
				exp_sel = '{valid: 1'b1, src: src};
				check_sel(xbar_sel_o[q], exp_sel, $sformatf("select of output %0d", q));
				exp_read[src] = 1'b1;
				ret_delay = r.rnd ? 1 + int'($urandom % 6) : int'(r.delay[q]);
				if (cyc + ret_delay > int'(r.hold[q])) begin
					release_q[q].push_back(cyc + ret_delay);
				end else begin
					release_q[q].push_back(int'(r.hold[q]));
				end
				credits[q]--;
				sent_flits[q]++;
				flit_in_pkt[q]++;
				if (flit_in_pkt[q] == PKT_FLITS) begin
					flit_in_pkt[q] = 0;
					pkt_idx[q]++;
				end
			end
			credits[q] += int'(credit_i[q]);
		end
		for (int p = 0; p < NUM_PORTS; p++) begin
			if (cyc == 0) begin
				check_bit(ib_read_o[p], 1'b0, $sformatf("read %0d right after reset", p));
			end
			check_bit(ib_read_o[p], exp_read[p], $sformatf("read strobe of input %0d", p));
			check_bit(credit_o[p], exp_read[p], $sformatf("upstream credit of input %0d", p));
			buf_flits[p] -= int'(ib_read_o[p]);  // The buffer pops at the coming edge.
		end
		cyc++;
	endtask

	function automatic logic row_done();
		for (int q = 0; q < NUM_PORTS; q++) begin
			if (pkt_idx[q] < exp_order[q].size()) begin
				return 1'b0;
			end
		end
		return 1'b1;
	endfunction

	task automatic run_row(input int idx);
		row_t r;
		r = rows[idx];
		build_model(r);
		compare_table(r, idx);
		reset_row(r);
		while (!row_done()) begin
			step_cycle(r);
		end
		repeat (PKT_FLITS) begin
			step_cycle(r);  // Nothing more may leave.
		end
		for (int q = 0; q < NUM_PORTS; q++) begin
			check_count(sent_flits[q], exp_order[q].size() * PKT_FLITS,
				$sformatf("flits sent on output %0d in row %0d", q, idx));
			check_count(buf_flits[q], 0, $sformatf("flits left at input %0d in row %0d", q, idx));
		end
	endtask

	task automatic clear_row(input int i, input coord_t addr);
		rows[i]      = '0;
		rows[i].addr = addr;
		for (int q = 0; q < NUM_PORTS; q++) begin
			rows[i].delay[q] = 3'd1;  // Sinks free each slot one cycle later.
		end
	endtask

	task automatic build_table();
		coord_t home;
		coord_t yx_dest [5];
		port_e  yx_port [5];
		home = '{y: 4'd5, x: 4'd5};
		yx_dest[0] = '{y: 4'd2, x: 4'd9};  // Y first, so north despite the larger x.
		yx_port[0] = PORT_N;
		yx_dest[1] = '{y: 4'd9, x: 4'd1};
		yx_port[1] = PORT_S;
		yx_dest[2] = '{y: 4'd5, x: 4'd1};
		yx_port[2] = PORT_W;
		yx_dest[3] = '{y: 4'd5, x: 4'd12};
		yx_port[3] = PORT_E;
		yx_dest[4] = home;
		yx_port[4] = PORT_L;
		for (int i = 0; i < 5; i++) begin
			clear_row(i, home);
			rows[i].pkts[PORT_L] = 3'd1;
			rows[i].dest[PORT_L] = yx_dest[i];
			rows[i].order[yx_port[i]][0] = PORT_L;
		end
		// Three inputs with two packets each, all heading east.
		clear_row(5, home);
		rows[5].pkts[PORT_N] = 3'd2;
		rows[5].pkts[PORT_W] = 3'd2;
		rows[5].pkts[PORT_L] = 3'd2;
		rows[5].dest[PORT_N] = '{y: 4'd5, x: 4'd9};
		rows[5].dest[PORT_W] = '{y: 4'd5, x: 4'd9};
		rows[5].dest[PORT_L] = '{y: 4'd5, x: 4'd9};
		rows[5].order[PORT_E] = seq(PORT_N, PORT_W, PORT_L, PORT_N, PORT_W, PORT_L);
		// The south sink keeps its credits for 30 cycles.
		clear_row(6, home);
		rows[6].pkts[PORT_N]  = 3'd1;
		rows[6].pkts[PORT_L]  = 3'd2;
		rows[6].dest[PORT_N]  = '{y: 4'd9, x: 4'd5};
		rows[6].dest[PORT_L]  = '{y: 4'd12, x: 4'd3};
		rows[6].hold[PORT_S]  = 8'd30;
		rows[6].order[PORT_S] = seq(PORT_N, PORT_L, PORT_L, PORT_N, PORT_N, PORT_N);
		// Four inputs, four different outputs.
		clear_row(7, home);
		rows[7].pkts[PORT_N] = 3'd1;
		rows[7].pkts[PORT_S] = 3'd1;
		rows[7].pkts[PORT_W] = 3'd1;
		rows[7].pkts[PORT_E] = 3'd1;
		rows[7].dest[PORT_N] = '{y: 4'd9, x: 4'd5};
		rows[7].dest[PORT_S] = '{y: 4'd1, x: 4'd5};
		rows[7].dest[PORT_W] = '{y: 4'd5, x: 4'd12};
		rows[7].dest[PORT_E] = '{y: 4'd5, x: 4'd1};
		rows[7].order[PORT_S][0] = PORT_N;
		rows[7].order[PORT_N][0] = PORT_S;
		rows[7].order[PORT_E][0] = PORT_W;
		rows[7].order[PORT_W][0] = PORT_E;
		for (int i = 8; i < NUM_ROWS; i++) begin
			rows[i]     = rows[i - 3];
			rows[i].rnd = 1'b1;
		end
	endtask

	initial begin
		repeat (NUM_ROWS * ROW_CYCLES) @(posedge clk);
		$display("Timeout: the run did not end within %0d cycles", NUM_ROWS * ROW_CYCLES);
		stop_failed();
	end

	initial begin
		void'($urandom(99065));
		rst_n_i       = 1'b0;
		router_addr_i = '0;
		ib_valid_i    = '0;
		credit_i      = '0;
		for (int p = 0; p < NUM_PORTS; p++) begin
			hdr_dest_i[p] = '0;
		end
		cyc = 0;
		build_table();
		for (int i = 0; i < NUM_ROWS; i++) begin
			run_row(i);
		end
		$display("sim passed");
		$finish;
	end

endmodule

// File: build.f
router_pkg.sv
input_route_ctrl.sv
output_credit_ctrl.sv
switch_allocator.sv
router_arbiter.sv
tb_router_arbiter.sv

// File: run_sim.sh
#!/bin/sh
# Builds the router testbench with Verilator, runs it and checks the log.
rm -rf obj_dir sim.log
verilator --binary --timing --assert -Wno-fatal --top-module tb_router_arbiter \
	-f build.f -o tb_router_arbiter || { echo "Build error"; exit 1; }
./obj_dir/tb_router_arbiter > sim.log 2>&1
cat sim.log
grep -q "sim failed" sim.log && { echo "Result: FAIL"; exit 1; }
grep -q "sim passed" sim.log || { echo "Result: no pass line in log"; exit 1; }
echo "Result: PASS"
